//--- all.f
logic/rv_pkg.sv
logic/decode_if.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_issue_ctrl.sv
logic/rv_exec_top.sv
verif/tb_clkgen.sv
verif/rv_exec_tb.sv

//--- verif/rv_exec_tb.sv
// Random-instruction testbench for the execute subsystem, checks results against a register model
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

  localparam int NUM_TESTS      = 300;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 10 + 200;

  logic              clk;
  logic              rst_n;
  logic              req_i;
  rv_pkg::instr_t    instr_i;
  logic              ack_o;
  rv_pkg::word_t     result_o;
  logic              illegal_o;
  rv_pkg::reg_addr_t dbg_raddr_i;
  rv_pkg::word_t     dbg_rdata_o;

  // Architectural state as the ISA defines it
  rv_pkg::word_t model_regs [32];
  logic [31:0]   rng_state = 32'd87;
  int            cycle_count = 0;
  int            num_tests = 0;
  int            num_checks = 0;
  int            num_errors = 0;

  tb_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clkgen (.clk(clk), .rst_n(rst_n));

  rv_exec_top #(.NUM_REGS(32)) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .instr_i     (instr_i),
    .ack_o       (ack_o),
    .result_o    (result_o),
    .illegal_o   (illegal_o),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_o (dbg_rdata_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Legal forms per the base ISA where funct7 only matters for OP and the shifts
  function automatic logic model_legal(input rv_pkg::instr_t ins);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = ins[14:12];
    f7 = ins[31:25];
    case (ins[6:0])
      rv_pkg::OPC_LUI: return 1'b1;
      rv_pkg::OPC_OP_IMM:
      begin
        if (f3 == 3'd1)
          return f7 == 7'h00;
        if (f3 == 3'd5)
          return (f7 == 7'h00) || (f7 == 7'h20);
        return 1'b1;
      end
      rv_pkg::OPC_OP:
      begin
        if ((f3 == 3'd0) || (f3 == 3'd5))
          return (f7 == 7'h00) || (f7 == 7'h20);
        return f7 == 7'h00;
      end
      default: return 1'b0;
    endcase
  endfunction

  // Expected rd value from rs1 value a and rs2 value b
  function automatic rv_pkg::word_t model_result(input rv_pkg::instr_t ins,
                                                 input rv_pkg::word_t a,
                                                 input rv_pkg::word_t b);
    rv_pkg::word_t opnd;
    logic [4:0]    sh;
    logic          alt;
    if (ins[6:0] == rv_pkg::OPC_LUI)
      return {ins[31:12], 12'h000};
    opnd = (ins[6:0] == rv_pkg::OPC_OP) ? b : {{20{ins[31]}}, ins[31:20]};
    sh   = opnd[4:0];
    alt  = ins[30];
    case (ins[14:12])
      3'd0: return (alt && (ins[6:0] == rv_pkg::OPC_OP)) ? a - opnd : a + opnd;
      3'd1: return a << sh;
      // Signed compare by flipping both sign bits
      3'd2: return ((a ^ 32'h8000_0000) < (opnd ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      3'd3: return (a < opnd) ? 32'd1 : 32'd0;
      3'd4: return a ^ opnd;
      3'd5:
      begin
        if (alt && a[31])
          return (a >> sh) | ~(32'hFFFF_FFFF >> sh);
        return a >> sh;
      end
      3'd6: return a | opnd;
      default: return a & opnd;
    endcase
  endfunction

  task automatic check_word(input string name, input rv_pkg::word_t exp_val,
                            input rv_pkg::word_t act_val);
    num_checks++;
    if (act_val !== exp_val)
    begin
      num_errors++;
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    num_checks++;
    if (act_val !== exp_val)
    begin
      num_errors++;
      $display("[FAIL] t=%0t %s expected=%b actual=%b", $time, name, exp_val, act_val);
    end
  endtask

  task automatic report_violation(input string what);
    num_errors++;
    $display("[ERROR] t=%0t handshake violation: %s", $time, what);
  endtask

  // Mostly legal OP, OP-IMM and LUI, with x0 favoured as rd and source
  task automatic gen_instr(output rv_pkg::instr_t ins);
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    next_rand(r);
    next_rand(s);
    rd    = (s[2:0] == 3'd0) ? 5'd0 : r[11:7];
    rs1   = (s[5:3] == 3'd0) ? 5'd0 : r[19:15];
    rs2   = (s[8:6] == 3'd0) ? 5'd0 : r[24:20];
    f3    = s[14:12];
    imm12 = s[31:20];
    if (s[19:16] < 4'd6)
      ins = {((f3 == 3'd0 || f3 == 3'd5) && s[15]) ? 7'h20 : 7'h00,
             rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    else if (s[19:16] < 4'd12)
    begin
      if (f3 == 3'd1)
        imm12[11:5] = 7'h00;
      else if (f3 == 3'd5)
        imm12[11:5] = s[15] ? 7'h20 : 7'h00;
      ins = {imm12, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
    end
    else if (s[19:16] < 4'd14)
      ins = {s[31:12], rd, rv_pkg::OPC_LUI};
    else if (s[19:16] == 4'd14)
      ins = r;
    // OP with funct7 bit 0 set is never a valid encoding
    else
      ins = {s[31:25] | 7'h01, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endtask

  // Full register dump through the debug port that starts and ends on a falling edge
  task automatic dump_regs();
    for (int i = 0; i < 32; i++)
    begin
      dbg_raddr_i = i[4:0];
      @(negedge clk);
      check_word($sformatf("dbg_rdata_o[x%0d]", i), model_regs[i], dbg_rdata_o);
    end
  endtask

  // One full four-phase transfer that starts and ends on a falling edge
  task automatic run_instr(input rv_pkg::instr_t ins, input int idx);
    rv_pkg::word_t expected;
    rv_pkg::word_t held;
    logic          legal;
    logic [4:0]    rd;
    logic [31:0]   r;
    int            errs_before;
    errs_before = num_errors;
    rd       = ins[11:7];
    legal    = model_legal(ins);
    expected = model_result(ins, model_regs[ins[19:15]], model_regs[ins[24:20]]);
    instr_i     = ins;
    req_i       = 1'b1;
    dbg_raddr_i = rd;
    @(negedge clk);
    while (!ack_o)
      @(negedge clk);
    check_flag("illegal_o", !legal, illegal_o);
    if (legal)
      check_word("result_o", expected, result_o);
    // x0 stays zero whatever is written to it
    if (legal && (rd != 5'd0))
      model_regs[rd] = expected;
    check_word("dbg_rdata_o", model_regs[rd], dbg_rdata_o);
    held = result_o;
    next_rand(r);
    repeat (r % 4)
    begin
      @(negedge clk);
      if (!ack_o)
        report_violation("ack_o dropped while req_i was still high");
      check_word("result_o", held, result_o);
    end
    req_i = 1'b0;
    @(negedge clk);
    while (ack_o)
      @(negedge clk);
    num_tests++;
    $display("test %0d instr=%h illegal=%b %s", idx, ins, !legal,
             (num_errors == errs_before) ? "ok" : "mismatch");
  endtask

  // ack_o may only rise while a request is pending
  always @(posedge ack_o)
  begin
    if (!req_i)
      report_violation("ack_o rose while req_i was low");
  end

  // Ends a run that stops making progress
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    rv_pkg::instr_t ins;
    req_i       = 1'b0;
    instr_i     = '0;
    dbg_raddr_i = '0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    @(posedge rst_n);
    @(negedge clk);
    check_flag("ack_o", 1'b0, ack_o);
    dump_regs();
    num_tests++;
    $display("reset state test %s", (num_errors == 0) ? "ok" : "mismatch");
    for (int n = 0; n < NUM_TESTS; n++)
    begin
      gen_instr(ins);
      run_instr(ins, n);
    end
    // Illegal words and x0 writes must not have touched any register
    dump_regs();
    num_tests++;
    $display("final register dump done");
    $display("tests=%0d checks=%0d errors=%0d", num_tests, num_checks, num_errors);
    if (num_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
// Testbench clock and reset source, instantiated once by the execute subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
)
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the register updates
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/rv_exec_top.sv
// Top level of the execute subsystem, wires issue control, decoder, register file and ALU
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
#(
  // 32 for RV32I, 16 for RV32E
  parameter int NUM_REGS = 32
)
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  // Four-phase request channel
  input  wire logic          req_i,
  input  rv_pkg::instr_t     instr_i,
  output logic               ack_o,
  // Valid while ack_o is high
  output rv_pkg::word_t      result_o,
  output logic               illegal_o,
  // Debug register read
  input  rv_pkg::reg_addr_t  dbg_raddr_i,
  output rv_pkg::word_t      dbg_rdata_o
);

  rv_pkg::instr_t instr;
  rv_pkg::word_t  rdata_a;
  rv_pkg::word_t  rdata_b;
  rv_pkg::word_t  alu_result;
  logic           we;

  decode_if dec_if ();

  rv_issue_ctrl u_issue_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .instr_i      (instr_i),
    .ack_o        (ack_o),
    .instr_o      (instr),
    .we_o         (we),
    .alu_result_i (alu_result),
    .result_o     (result_o),
    .dec          (dec_if.ctrl)
  );

  rv_decoder #(
    .NUM_REGS (NUM_REGS)
  ) u_decoder (
    .instr_i (instr),
    .dec     (dec_if.decoder)
  );

  // Write address is the decoded rd, carried in through the interface
  rv_regfile #(
    .NUM_REGS (NUM_REGS)
  ) u_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_o (dbg_rdata_o),
    .rdata_a_o   (rdata_a),
    .rdata_b_o   (rdata_b),
    .we_i        (we),
    .wdata_i     (alu_result),
    .dec         (dec_if.regfile)
  );

  rv_alu u_alu (
    .rs1_i    (rdata_a),
    .rs2_i    (rdata_b),
    .dec      (dec_if.alu),
    .result_o (alu_result)
  );

  assign illegal_o = dec_if.illegal;

endmodule

`default_nettype wire

//--- logic/rv_issue_ctrl.sv
// Four-phase req/ack controller, latches the instruction, drives write-back and holds the result
`timescale 1ns/1ps
`default_nettype none

module rv_issue_ctrl
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      req_i,
  input  rv_pkg::instr_t instr_i,
  output logic           ack_o,
  output rv_pkg::instr_t instr_o,
  output logic           we_o,
  // ALU result in, held copy out for the ack phase
  input  rv_pkg::word_t  alu_result_i,
  output rv_pkg::word_t  result_o,
  decode_if.ctrl         dec
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK
  } state_e;

  state_e         state_q;
  rv_pkg::instr_t instr_q;
  rv_pkg::word_t  result_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
    begin
      case (state_q)
        // ack_o is low here, so a high req_i is a new request
        IDLE:    if (req_i) state_q <= EXEC;
        EXEC:    state_q <= ACK;
        // Stay while the requester keeps req_i high
        ACK:     if (!req_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction is captured on the accepting edge
  always_ff @(posedge clk)
  begin
    if ((state_q == IDLE) && req_i)
      instr_q <= instr_i;
  end

  // Hold the result, a write to rs1 or rs2 would otherwise change it during ACK
  always_ff @(posedge clk)
  begin
    if (state_q == EXEC)
      result_q <= alu_result_i;
  end

  // Single write-back cycle, illegal encodings change no state
  assign we_o     = (state_q == EXEC) && dec.writes_rd && !dec.illegal;
  assign ack_o    = (state_q == ACK);
  assign instr_o  = instr_q;
  assign result_o = result_q;

endmodule

`default_nettype wire

//--- logic/rv_alu.sv
// Combinational RV32I integer ALU, operand B taken from rs2 or the decoded immediate
`timescale 1ns/1ps
`default_nettype none

module rv_alu
(
  input  rv_pkg::word_t  rs1_i,
  input  rv_pkg::word_t  rs2_i,
  decode_if.alu          dec,
  output rv_pkg::word_t  result_o
);

  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  // OP-IMM and LUI use the immediate
  assign op_b  = dec.use_imm ? dec.imm : rs2_i;
  // Only the low five bits count as shift amount
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  result_o = rs1_i + op_b;
      rv_pkg::ALU_SUB:  result_o = rs1_i - op_b;
      rv_pkg::ALU_SLL:  result_o = rs1_i << shamt;
      rv_pkg::ALU_SLT:  result_o = {31'b0, $signed(rs1_i) < $signed(op_b)};
      rv_pkg::ALU_SLTU: result_o = {31'b0, rs1_i < op_b};
      rv_pkg::ALU_XOR:  result_o = rs1_i ^ op_b;
      rv_pkg::ALU_SRL:  result_o = rs1_i >> shamt;
      // Arithmetic shift replicates the sign bit
      rv_pkg::ALU_SRA:  result_o = $unsigned($signed(rs1_i) >>> shamt);
      rv_pkg::ALU_OR:   result_o = rs1_i | op_b;
      rv_pkg::ALU_AND:  result_o = rs1_i & op_b;
      rv_pkg::ALU_LUI:  result_o = op_b;
      default:          result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_decoder.sv
// Instruction decoder for LUI, OP-IMM and OP, flags everything else as illegal
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
#(
  parameter int NUM_REGS = 32
)
(
  input  rv_pkg::instr_t  instr_i,
  decode_if.decoder       dec
);

  // funct7 values that select the base or alternate operation
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       bad_func;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign dec.rd_addr  = instr_i[11:7];
  assign dec.rs1_addr = instr_i[19:15];
  assign dec.rs2_addr = instr_i[24:20];

  always_comb
  begin
    dec.alu_op    = rv_pkg::ALU_ADD;
    // I-type immediate unless LUI overrides it
    dec.imm       = {{20{instr_i[31]}}, instr_i[31:20]};
    dec.use_imm   = 1'b0;
    dec.writes_rd = 1'b0;
    uses_rs1      = 1'b0;
    uses_rs2      = 1'b0;
    bad_func      = 1'b0;

    case (opcode)
      rv_pkg::OPC_LUI:
      begin
        dec.alu_op    = rv_pkg::ALU_LUI;
        dec.imm       = {instr_i[31:12], 12'h000};
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
      end

      rv_pkg::OPC_OP_IMM:
      begin
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
        uses_rs1      = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = rv_pkg::ALU_ADD;
          3'b010: dec.alu_op = rv_pkg::ALU_SLT;
          3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100: dec.alu_op = rv_pkg::ALU_XOR;
          3'b110: dec.alu_op = rv_pkg::ALU_OR;
          3'b111: dec.alu_op = rv_pkg::ALU_AND;
          // Shifts keep funct7 in the immediate's upper bits
          3'b001:
          begin
            dec.alu_op = rv_pkg::ALU_SLL;
            bad_func   = (funct7 != F7_BASE);
          end
          default:
          begin
            dec.alu_op = (funct7 == F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            bad_func   = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
        endcase
      end

      rv_pkg::OPC_OP:
      begin
        dec.writes_rd = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = (funct7 == F7_ALT) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001: dec.alu_op = rv_pkg::ALU_SLL;
          3'b010: dec.alu_op = rv_pkg::ALU_SLT;
          3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100: dec.alu_op = rv_pkg::ALU_XOR;
          3'b101: dec.alu_op = (funct7 == F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110: dec.alu_op = rv_pkg::ALU_OR;
          default: dec.alu_op = rv_pkg::ALU_AND;
        endcase
        // Only ADD/SUB and SRL/SRA have an alternate form
        if ((funct3 == 3'b000) || (funct3 == 3'b101))
          bad_func = (funct7 != F7_BASE) && (funct7 != F7_ALT);
        else
          bad_func = (funct7 != F7_BASE);
      end

      default:
      begin
        bad_func = 1'b1;
      end
    endcase
  end

  // Register range check, this is what keeps RV32E off x16 to x31
  always_comb
  begin
    dec.illegal = bad_func;
    if (dec.writes_rd && (int'(dec.rd_addr) >= NUM_REGS))
      dec.illegal = 1'b1;
    if (uses_rs1 && (int'(dec.rs1_addr) >= NUM_REGS))
      dec.illegal = 1'b1;
    if (uses_rs2 && (int'(dec.rs2_addr) >= NUM_REGS))
      dec.illegal = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
// Flip-flop register file, x0 hard-wired to zero, two operand reads, one debug read, one write
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
#(
  parameter int NUM_REGS = 32
)
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  // Debug read port, any index
  input  rv_pkg::reg_addr_t  dbg_raddr_i,
  output rv_pkg::word_t      dbg_rdata_o,
  // Operand read data towards the ALU
  output rv_pkg::word_t      rdata_a_o,
  output rv_pkg::word_t      rdata_b_o,
  // Write port, address comes from the decoded rd
  input  wire logic          we_i,
  input  rv_pkg::word_t      wdata_i,
  decode_if.regfile          dec
);

  rv_pkg::word_t        rf_q [NUM_REGS];
  logic [NUM_REGS-1:1]  we_dec;

  // Indices at or beyond NUM_REGS read as zero
  function automatic rv_pkg::word_t read_reg(input rv_pkg::reg_addr_t addr);
    rv_pkg::word_t data;
    data = '0;
    for (int k = 0; k < NUM_REGS; k++)
    begin
      if (addr == k)
        data = rf_q[k];
    end
    return data;
  endfunction

  // One-hot write enable, no entry for x0
  always_comb
  begin
    for (int k = 1; k < NUM_REGS; k++)
    begin
      we_dec[k] = we_i && (dec.rd_addr == k);
    end
  end

  for (genvar g = 1; g < NUM_REGS; g++)
  begin : gen_reg
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
        rf_q[g] <= '0;
      else if (we_dec[g])
        rf_q[g] <= wdata_i;
    end
  end

  // x0 is a constant, writes to it vanish
  assign rf_q[0] = '0;

  always_comb
  begin
    rdata_a_o   = read_reg(dec.rs1_addr);
    rdata_b_o   = read_reg(dec.rs2_addr);
    dbg_rdata_o = read_reg(dbg_raddr_i);
  end

endmodule

`default_nettype wire

//--- logic/decode_if.sv
// Decoded instruction fields, driven by the decoder and read by regfile, ALU and issue control
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

  rv_pkg::alu_op_t   alu_op;
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::reg_addr_t rd_addr;
  // Sign-extended I-type, or U-type with low bits zero
  rv_pkg::word_t     imm;
  logic              use_imm;
  logic              writes_rd;
  logic              illegal;

  modport decoder (output alu_op, rs1_addr, rs2_addr, rd_addr, imm, use_imm, writes_rd, illegal);
  modport regfile (input rs1_addr, rs2_addr, rd_addr);
  modport alu (input alu_op, imm, use_imm);
  modport ctrl (input illegal, writes_rd);

endinterface

`default_nettype wire

//--- logic/rv_pkg.sv
// Shared types, opcodes and ALU operation codes, referenced by scoped name from each module
`default_nettype none

package rv_pkg;

  // One architectural register or data value
  typedef logic [31:0] word_t;

  // Register index, wide enough for x0 to x31
  typedef logic [4:0] reg_addr_t;

  // Raw instruction word as handed over by the requester
  typedef logic [31:0] instr_t;

  // ALU operation selector
  typedef logic [3:0] alu_op_t;

  // Major opcodes of the supported instruction classes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // ALU operations
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  // Passes the U-type immediate straight through
  localparam alu_op_t ALU_LUI  = 4'd10;

endpackage

`default_nettype wire
